// ==== design/dcache_pkg.sv ====
// Data cache package with shared widths, sizes, entry layout and controller states.
package dcache_pkg;

	// Bus and CPU port widths.
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  wmask_t;

	// ========================================================================
	// Cache geometry
	// ========================================================================
	localparam int unsigned INDEX_BITS = 6;
	localparam int unsigned LINE_COUNT = 1 << INDEX_BITS;

	typedef logic [INDEX_BITS-1:0] line_index_t;

	// One entry holds data, word address, dirty and valid.
	typedef logic [63:0] cache_entry_t;

	localparam int unsigned ENTRY_VALID_BIT = 0;
	localparam int unsigned ENTRY_DIRTY_BIT = 1;
	localparam int unsigned ENTRY_DATA_LSB  = 32;

	// ========================================================================
	// Backing memory
	// ========================================================================
	localparam int unsigned MEM_ADDR_BITS   = 10;
	localparam int unsigned MEM_WORDS       = 1 << MEM_ADDR_BITS;
	localparam int unsigned MEM_WAIT_CYCLES = 2;
	localparam int unsigned MEM_WAIT_BITS   = $clog2(MEM_WAIT_CYCLES + 1);

	typedef logic [MEM_ADDR_BITS-1:0] mem_index_t;
	typedef logic [MEM_WAIT_BITS-1:0] wait_count_t;

	// Controller states.
	typedef enum logic [3:0] {
		idle,
		flush_setup,
		flush_check,
		flush_write,
		flush_next,
		pass_through,
		write_setup,
		write_wait,
		read_setup,
		read_wb_wait,
		read_bus_wait,
		initialize
	} cache_state_t;

	// Packs a word and its address into an entry.
	function automatic cache_entry_t make_entry(data_t data, addr_t address, logic dirty,
			logic valid);
		cache_entry_t entry;
		entry = '0;
		entry[ENTRY_DATA_LSB +: 32] = data;
		entry[31:2] = address[31:2];
		entry[ENTRY_DIRTY_BIT] = dirty;
		entry[ENTRY_VALID_BIT] = valid;
		return entry;
	endfunction

endpackage

// ==== design/dcache_bram.sv ====
// Cache entry RAM, single port, registered read with new data on a write.
`timescale 1ns/1ps

module dcache_bram (
	input  logic                     i_clock,
	input  logic                     i_write,
	input  dcache_pkg::line_index_t  i_index,
	input  dcache_pkg::cache_entry_t i_wdata,
	output dcache_pkg::cache_entry_t o_rdata
);

	// Entry storage, cleared by the controller sweep.
	dcache_pkg::cache_entry_t ram [0:dcache_pkg::LINE_COUNT-1];

	always_ff @(posedge i_clock) begin
		if (i_write) begin
			ram[i_index] <= i_wdata;
		end
	end

	// Read port.
	// A write shows its own data in the next cycle.
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			o_rdata <= i_wdata;
		end else begin
			o_rdata <= ram[i_index];
		end
	end

endmodule

// ==== design/dcache_controller.sv ====
// Direct-mapped write-back data cache controller FSM.
`timescale 1ns/1ps

module dcache_controller (
	input  logic                     i_clock,
	input  logic                     i_reset,

	// CPU port.
	input  logic                     i_request,
	input  logic                     i_rw,
	input  logic                     i_flush,
	input  logic                     i_cacheable,
	input  dcache_pkg::addr_t        i_address,
	input  dcache_pkg::data_t        i_wdata,
	input  dcache_pkg::wmask_t       i_wmask,
	output logic                     o_ready,
	output dcache_pkg::data_t        o_rdata,

	// Bus.
	output logic                     o_bus_request,
	output logic                     o_bus_rw,
	output dcache_pkg::addr_t        o_bus_address,
	output dcache_pkg::data_t        o_bus_wdata,
	output dcache_pkg::wmask_t       o_bus_wmask,
	input  logic                     i_bus_ready,
	input  dcache_pkg::data_t        i_bus_rdata,

	// Cache RAM.
	output logic                     o_cache_write,
	output dcache_pkg::line_index_t  o_cache_index,
	output dcache_pkg::cache_entry_t o_cache_wdata,
	input  dcache_pkg::cache_entry_t i_cache_rdata
);

	dcache_pkg::cache_state_t state;
	dcache_pkg::cache_state_t next_state;

	// Line counter for flush and sweep, MSB set means done.
	logic [dcache_pkg::INDEX_BITS:0] line_count;
	logic [dcache_pkg::INDEX_BITS:0] next_line_count;

	logic              entry_valid;
	logic              entry_dirty;
	dcache_pkg::addr_t entry_address;
	dcache_pkg::data_t entry_data;
	logic              entry_match;
	logic              walk_done;

	// Fields of the entry read last cycle.
	assign entry_valid   = i_cache_rdata[dcache_pkg::ENTRY_VALID_BIT];
	assign entry_dirty   = i_cache_rdata[dcache_pkg::ENTRY_DIRTY_BIT];
	assign entry_address = {i_cache_rdata[31:2], 2'b00};
	assign entry_data    = i_cache_rdata[dcache_pkg::ENTRY_DATA_LSB +: 32];

	assign entry_match = (entry_address[31:2] == i_address[31:2]);
	assign walk_done   = line_count[dcache_pkg::INDEX_BITS];

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state      <= dcache_pkg::initialize;
			line_count <= '0;
		end else begin
			state      <= next_state;
			line_count <= next_line_count;
		end
	end

	always_comb begin
		next_state      = state;
		next_line_count = line_count;

		o_ready = 1'b0;
		o_rdata = '0;

		o_bus_request = 1'b0;
		o_bus_rw      = 1'b0;
		o_bus_address = '0;
		o_bus_wdata   = '0;
		o_bus_wmask   = 4'b0000;

		// The request address indexes the RAM unless a walk is running.
		o_cache_write = 1'b0;
		o_cache_index = i_address[dcache_pkg::INDEX_BITS+1:2];
		o_cache_wdata = '0;

		case (state)
			dcache_pkg::idle: begin
				if (i_request) begin
					if (i_flush) begin
						next_line_count = '0;
						next_state = dcache_pkg::flush_setup;
					end else if (!i_cacheable) begin
						next_state = dcache_pkg::pass_through;
					end else if (i_rw) begin
						next_state = dcache_pkg::write_setup;
					end else begin
						next_state = dcache_pkg::read_setup;
					end
				end
			end

			// ================================================================
			// Flush
			// ================================================================
			dcache_pkg::flush_setup: begin
				o_cache_index = line_count[dcache_pkg::INDEX_BITS-1:0];
				if (walk_done) begin
					o_ready = 1'b1;
					next_state = dcache_pkg::idle;
				end else begin
					next_state = dcache_pkg::flush_check;
				end
			end

			dcache_pkg::flush_check: begin
				o_cache_index = line_count[dcache_pkg::INDEX_BITS-1:0];
				if (entry_valid && entry_dirty) begin
					next_state = dcache_pkg::flush_write;
				end else begin
					next_line_count = line_count + 1'b1;
					next_state = dcache_pkg::flush_setup;
				end
			end

			dcache_pkg::flush_write: begin
				o_cache_index = line_count[dcache_pkg::INDEX_BITS-1:0];
				o_bus_request = 1'b1;
				o_bus_rw      = 1'b1;
				o_bus_address = entry_address;
				o_bus_wdata   = entry_data;
				o_bus_wmask   = 4'b1111;
				if (i_bus_ready) begin
					// Line stays valid but is clean now.
					o_cache_write = 1'b1;
					o_cache_wdata = dcache_pkg::make_entry(entry_data, entry_address, 1'b0, 1'b1);
					next_state = dcache_pkg::flush_next;
				end
			end

			// Bus request drops here for one cycle.
			dcache_pkg::flush_next: begin
				o_cache_index = line_count[dcache_pkg::INDEX_BITS-1:0];
				next_line_count = line_count + 1'b1;
				next_state = dcache_pkg::flush_setup;
			end

			// ================================================================
			// Uncached access
			// ================================================================
			dcache_pkg::pass_through: begin
				o_bus_request = i_request;
				o_bus_rw      = i_rw;
				o_bus_address = i_address;
				o_bus_wdata   = i_wdata;
				o_bus_wmask   = i_wmask;
				o_rdata       = i_bus_rdata;
				o_ready       = i_bus_ready;
				if (!i_request) begin
					next_state = dcache_pkg::idle;
				end
			end

			// ================================================================
			// Cached write
			// ================================================================
			dcache_pkg::write_setup: begin
				if (entry_valid && entry_dirty && !entry_match) begin
					next_state = dcache_pkg::write_wait;
				end else begin
					o_cache_write = 1'b1;
					o_cache_wdata = dcache_pkg::make_entry(i_wdata, i_address, 1'b1, 1'b1);
					o_ready = 1'b1;
					next_state = dcache_pkg::idle;
				end
			end

			// Old word goes back, then the new word is stored dirty.
			dcache_pkg::write_wait: begin
				o_bus_request = 1'b1;
				o_bus_rw      = 1'b1;
				o_bus_address = entry_address;
				o_bus_wdata   = entry_data;
				o_bus_wmask   = 4'b1111;
				if (i_bus_ready) begin
					o_cache_write = 1'b1;
					o_cache_wdata = dcache_pkg::make_entry(i_wdata, i_address, 1'b1, 1'b1);
					o_ready = 1'b1;
					next_state = dcache_pkg::idle;
				end
			end

			// ================================================================
			// Cached read
			// ================================================================
			dcache_pkg::read_setup: begin
				o_rdata = entry_data;
				if (entry_valid && entry_match) begin
					o_ready = 1'b1;
					next_state = dcache_pkg::idle;
				end else if (entry_valid && entry_dirty) begin
					next_state = dcache_pkg::read_wb_wait;
				end else begin
					next_state = dcache_pkg::read_bus_wait;
				end
			end

			// Write-back of the victim.
			// Marking it clean sends the FSM back through read_setup to refill.
			dcache_pkg::read_wb_wait: begin
				o_bus_request = 1'b1;
				o_bus_rw      = 1'b1;
				o_bus_address = entry_address;
				o_bus_wdata   = entry_data;
				o_bus_wmask   = 4'b1111;
				if (i_bus_ready) begin
					o_cache_write = 1'b1;
					o_cache_wdata = dcache_pkg::make_entry(entry_data, entry_address, 1'b0, 1'b1);
					next_state = dcache_pkg::read_setup;
				end
			end

			dcache_pkg::read_bus_wait: begin
				o_bus_request = 1'b1;
				o_bus_address = i_address;
				o_rdata       = i_bus_rdata;
				if (i_bus_ready) begin
					o_cache_write = 1'b1;
					o_cache_wdata = dcache_pkg::make_entry(i_bus_rdata, i_address, 1'b0, 1'b1);
					o_ready = 1'b1;
					next_state = dcache_pkg::idle;
				end
			end

			// ================================================================
			// Initialize sweep
			// ================================================================
			dcache_pkg::initialize: begin
				o_cache_index = line_count[dcache_pkg::INDEX_BITS-1:0];
				if (walk_done) begin
					next_line_count = '0;
					next_state = dcache_pkg::idle;
				end else begin
					o_cache_write = 1'b1;
					o_cache_wdata = '0;
					next_line_count = line_count + 1'b1;
				end
			end

			default: begin
				next_state = dcache_pkg::idle;
			end
		endcase
	end

endmodule

// ==== design/bus_memory.sv ====
// Backing memory on the bus, fixed wait states and byte-masked writes.
`timescale 1ns/1ps

module bus_memory (
	input  logic               i_clock,
	input  logic               i_reset,
	input  logic               i_request,
	input  logic               i_rw,
	input  dcache_pkg::addr_t  i_address,
	input  dcache_pkg::data_t  i_wdata,
	input  dcache_pkg::wmask_t i_wmask,
	output logic               o_ready,
	output dcache_pkg::data_t  o_rdata
);

	dcache_pkg::data_t mem [0:dcache_pkg::MEM_WORDS-1];

	dcache_pkg::wait_count_t wait_count;
	dcache_pkg::mem_index_t  word_index;
	logic                    done;
	logic                    fire;

	assign word_index = i_address[dcache_pkg::MEM_ADDR_BITS+1:2];

	// Access happens once the wait states are used up.
	assign fire = i_request && !done &&
		(wait_count == dcache_pkg::wait_count_t'(dcache_pkg::MEM_WAIT_CYCLES));

	initial begin
		for (int i = 0; i < dcache_pkg::MEM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	// Wait counter, rearmed when the request drops.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wait_count <= '0;
			done       <= 1'b0;
			o_ready    <= 1'b0;
		end else begin
			o_ready <= fire;
			if (!i_request) begin
				wait_count <= '0;
				done       <= 1'b0;
			end else if (fire) begin
				done <= 1'b1;
			end else if (!done) begin
				wait_count <= wait_count + 1'b1;
			end
		end
	end

	// Word access.
	always_ff @(posedge i_clock) begin
		if (fire) begin
			if (i_rw) begin
				for (int b = 0; b < 4; b++) begin
					if (i_wmask[b]) begin
						mem[word_index][b*8 +: 8] <= i_wdata[b*8 +: 8];
					end
				end
			end else begin
				o_rdata <= mem[word_index];
			end
		end
	end

endmodule

// ==== design/dcache_top.sv ====
// Data cache subsystem top with controller, entry RAM and backing memory.
`timescale 1ns/1ps

module dcache_top (
	input  logic               i_clock,
	input  logic               i_reset,
	input  logic               i_request,
	input  logic               i_rw,
	input  logic               i_flush,
	input  logic               i_cacheable,
	input  dcache_pkg::addr_t  i_address,
	input  dcache_pkg::data_t  i_wdata,
	input  dcache_pkg::wmask_t i_wmask,
	output logic               o_ready,
	output dcache_pkg::data_t  o_rdata
);

	// Bus between controller and memory.
	logic               bus_request;
	logic               bus_rw;
	dcache_pkg::addr_t  bus_address;
	dcache_pkg::data_t  bus_wdata;
	dcache_pkg::wmask_t bus_wmask;
	logic               bus_ready;
	dcache_pkg::data_t  bus_rdata;

	// Entry RAM port.
	logic                     cache_write;
	dcache_pkg::line_index_t  cache_index;
	dcache_pkg::cache_entry_t cache_wdata;
	dcache_pkg::cache_entry_t cache_rdata;

	dcache_controller u_controller (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_request     (i_request),
		.i_rw          (i_rw),
		.i_flush       (i_flush),
		.i_cacheable   (i_cacheable),
		.i_address     (i_address),
		.i_wdata       (i_wdata),
		.i_wmask       (i_wmask),
		.o_ready       (o_ready),
		.o_rdata       (o_rdata),
		.o_bus_request (bus_request),
		.o_bus_rw      (bus_rw),
		.o_bus_address (bus_address),
		.o_bus_wdata   (bus_wdata),
		.o_bus_wmask   (bus_wmask),
		.i_bus_ready   (bus_ready),
		.i_bus_rdata   (bus_rdata),
		.o_cache_write (cache_write),
		.o_cache_index (cache_index),
		.o_cache_wdata (cache_wdata),
		.i_cache_rdata (cache_rdata)
	);

	dcache_bram u_bram (
		.i_clock (i_clock),
		.i_write (cache_write),
		.i_index (cache_index),
		.i_wdata (cache_wdata),
		.o_rdata (cache_rdata)
	);

	bus_memory u_memory (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_request (bus_request),
		.i_rw      (bus_rw),
		.i_address (bus_address),
		.i_wdata   (bus_wdata),
		.i_wmask   (bus_wmask),
		.o_ready   (bus_ready),
		.o_rdata   (bus_rdata)
	);

endmodule

// ==== tb/dcache_sva.sv ====
// Bound assertions on the cache controller for ready and bus request rules.
`timescale 1ns/1ps

module dcache_sva (
	input logic                     i_clock,
	input logic                     i_reset,
	input logic                     i_request,
	input logic                     i_ready,
	input logic                     i_bus_request,
	input logic                     i_bus_rw,
	input dcache_pkg::addr_t        i_bus_address,
	input logic                     i_bus_ready,
	input dcache_pkg::cache_state_t i_state
);

	// Ready only answers a held request.
	a_ready_with_request: assert property (
		@(posedge i_clock) disable iff (i_reset)
		i_ready |-> i_request
	) else $error("o_ready high without a CPU request");

	// Quiet while in reset and during the line sweep.
	a_quiet_in_init: assert property (
		@(posedge i_clock)
		(i_reset || i_state == dcache_pkg::initialize) |-> (!i_ready && !i_bus_request)
	) else $error("o_ready or bus request active during reset or sweep");

	// A waiting bus request keeps its address and direction.
	a_bus_stable: assert property (
		@(posedge i_clock) disable iff (i_reset)
		(i_bus_request && !i_bus_ready) |=>
			(i_bus_request && $stable(i_bus_address) && $stable(i_bus_rw))
	) else $error("bus request dropped or changed before bus ready");

endmodule

// ==== tb/dcache_tb.sv ====
// Testbench for the data cache subsystem with a reference memory model.
`timescale 1ns/1ps

module dcache_tb;

	localparam dcache_pkg::addr_t UNCACHED_BASE = 32'h0000_0800;
	localparam int RANDOM_OPS = 200;
	localparam int MODEL_WORDS = 1024;
	// Init, a few flushes of about 600 cycles each and 200 accesses under 15 cycles.
	localparam int TIMEOUT_CYCLES = 20000;
	localparam logic [31:0] SEED = 32'hae53a48a;

	logic               i_clock;
	logic               i_reset;
	logic               i_request;
	logic               i_rw;
	logic               i_flush;
	logic               i_cacheable;
	dcache_pkg::addr_t  i_address;
	dcache_pkg::data_t  i_wdata;
	dcache_pkg::wmask_t i_wmask;
	logic               o_ready;
	dcache_pkg::data_t  o_rdata;

	// CPU view of memory, and what the backing memory holds.
	dcache_pkg::data_t view_model [0:MODEL_WORDS-1];
	dcache_pkg::data_t mem_model [0:MODEL_WORDS-1];

	logic              check_pending;
	dcache_pkg::data_t check_expected;
	string             test_name;
	int                test_errors;
	int                error_count;
	int                check_count;
	int                test_count;
	int                failed_tests;
	int                cycle_count;

	dcache_top dcache_top_inst (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_request   (i_request),
		.i_rw        (i_rw),
		.i_flush     (i_flush),
		.i_cacheable (i_cacheable),
		.i_address   (i_address),
		.i_wdata     (i_wdata),
		.i_wmask     (i_wmask),
		.o_ready     (o_ready),
		.o_rdata     (o_rdata)
	);

	bind dcache_controller dcache_sva sva_inst (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_request     (i_request),
		.i_ready       (o_ready),
		.i_bus_request (o_bus_request),
		.i_bus_rw      (o_bus_rw),
		.i_bus_address (o_bus_address),
		.i_bus_ready   (i_bus_ready),
		.i_state       (state)
	);

	initial begin
		i_clock = 1'b0;
		forever #5 i_clock = ~i_clock;
	end

	// ========================================================================
	// Reference model
	// ========================================================================
	function automatic dcache_pkg::data_t merge_bytes(dcache_pkg::data_t old_word,
			dcache_pkg::data_t new_word, dcache_pkg::wmask_t mask);
		dcache_pkg::data_t result;
		result = old_word;
		for (int b = 0; b < 4; b++) begin
			if (mask[b]) begin
				result[b*8 +: 8] = new_word[b*8 +: 8];
			end
		end
		return result;
	endfunction

	// Expected read data, from the CPU view or straight from memory.
	function automatic dcache_pkg::data_t reference_read(dcache_pkg::addr_t address,
			logic from_memory);
		if (from_memory) begin
			return mem_model[address[11:2]];
		end
		return view_model[address[11:2]];
	endfunction

	// ========================================================================
	// Stimulus
	// ========================================================================
	task automatic drive_access(input logic rw, input logic cacheable, input logic flush,
			input dcache_pkg::addr_t address, input dcache_pkg::data_t wdata,
			input dcache_pkg::wmask_t wmask, output int latency);
		@(posedge i_clock);
		i_request   <= 1'b1;
		i_rw        <= rw;
		i_cacheable <= cacheable;
		i_flush     <= flush;
		i_address   <= address;
		i_wdata     <= wdata;
		i_wmask     <= wmask;
		latency = 0;
		@(negedge i_clock);
		while (!o_ready) begin
			@(posedge i_clock);
			latency++;
			@(negedge i_clock);
		end
		// Ready is taken at the coming edge.
		latency++;
		@(posedge i_clock);
		i_request <= 1'b0;
		i_flush   <= 1'b0;
	endtask

	task automatic cpu_write(input logic cacheable, input dcache_pkg::addr_t address,
			input dcache_pkg::data_t wdata, input dcache_pkg::wmask_t wmask);
		int latency;
		drive_access(1'b1, cacheable, 1'b0, address, wdata, wmask, latency);
		if (cacheable) begin
			view_model[address[11:2]] = wdata;
		end else begin
			view_model[address[11:2]] = merge_bytes(view_model[address[11:2]], wdata, wmask);
			mem_model[address[11:2]]  = merge_bytes(mem_model[address[11:2]], wdata, wmask);
		end
	endtask

	task automatic cpu_read(input logic cacheable, input dcache_pkg::addr_t address,
			input logic from_memory, output int latency);
		check_expected = reference_read(address, from_memory);
		check_pending = 1'b1;
		drive_access(1'b0, cacheable, 1'b0, address, '0, 4'b1111, latency);
		check_pending = 1'b0;
	endtask

	// After a flush memory holds every word the CPU sees.
	task automatic cpu_flush();
		int latency;
		drive_access(1'b0, 1'b1, 1'b1, '0, '0, 4'b0000, latency);
		for (int i = 0; i < MODEL_WORDS; i++) begin
			mem_model[i] = view_model[i];
		end
	endtask

	task automatic apply_reset();
		@(posedge i_clock);
		i_reset <= 1'b1;
		repeat (2) @(posedge i_clock);
		i_reset <= 1'b0;
		// Dirty lines are lost.
		for (int i = 0; i < MODEL_WORDS; i++) begin
			view_model[i] = mem_model[i];
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		test_count++;
		if (test_errors != 0) begin
			failed_tests++;
			$display("%s: %0d errors", test_name, test_errors);
		end else begin
			$display("%s: ok", test_name);
		end
	endtask

	// Compare process for read data.
	always @(negedge i_clock) begin
		if (check_pending && o_ready) begin
			check_count++;
			if (o_rdata !== check_expected) begin
				$display("ERROR %s: expected %h, actual %h", test_name, check_expected, o_rdata);
				test_errors++;
				error_count++;
			end
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge i_clock);
			cycle_count++;
		end
		$display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
		$display("Test failed");
		$finish;
	end

	// ========================================================================
	// Test sequence
	// ========================================================================
	initial begin
		int latency;
		int unsigned pick;
		dcache_pkg::addr_t address;
		dcache_pkg::data_t data;
		dcache_pkg::wmask_t mask;
		logic cacheable;
		logic rw;

		void'($urandom(SEED));
		i_reset = 1'b1;
		i_request = 1'b0;
		i_rw = 1'b0;
		i_flush = 1'b0;
		i_cacheable = 1'b0;
		i_address = '0;
		i_wdata = '0;
		i_wmask = 4'b0000;
		check_pending = 1'b0;
		check_expected = '0;
		error_count = 0;
		check_count = 0;
		test_count = 0;
		failed_tests = 0;
		for (int i = 0; i < MODEL_WORDS; i++) begin
			view_model[i] = '0;
			mem_model[i] = '0;
		end
		repeat (2) @(posedge i_clock);
		i_reset <= 1'b0;

		start_test("uncached_masks");
		cpu_write(1'b0, UNCACHED_BASE, 32'h1122_3344, 4'b1111);
		cpu_write(1'b0, UNCACHED_BASE, 32'haabb_ccdd, 4'b0101);
		cpu_write(1'b0, UNCACHED_BASE + 32'h4, 32'hdead_beef, 4'b1000);
		cpu_write(1'b0, UNCACHED_BASE + 32'h8, 32'hcafe_f00d, 4'b0110);
		cpu_read(1'b0, UNCACHED_BASE, 1'b0, latency);
		cpu_read(1'b0, UNCACHED_BASE + 32'h4, 1'b0, latency);
		cpu_read(1'b0, UNCACHED_BASE + 32'h8, 1'b0, latency);
		finish_test();

		start_test("cached_hit");
		cpu_write(1'b1, 32'h020, 32'h5a5a_1234, 4'b1111);
		cpu_read(1'b1, 32'h020, 1'b0, latency);
		check_count++;
		if (latency != 2) begin
			$display("ERROR %s: expected latency %0d, actual %0d", test_name, 2, latency);
			test_errors++;
			error_count++;
		end
		finish_test();

		// 0x0c0 and 0x1c0 share line 48.
		start_test("conflict_eviction");
		cpu_write(1'b1, 32'h0c0, 32'h0000_aaaa, 4'b1111);
		cpu_write(1'b1, 32'h1c0, 32'h0000_bbbb, 4'b0011);
		cpu_read(1'b1, 32'h0c0, 1'b0, latency);
		cpu_read(1'b1, 32'h1c0, 1'b0, latency);
		finish_test();

		start_test("flush_writeback");
		for (int i = 0; i < 4; i++) begin
			cpu_write(1'b1, 32'h600 + 32'(i * 4), 32'h7100_0000 + 32'(i), 4'b1111);
		end
		for (int i = 0; i < 4; i++) begin
			cpu_read(1'b0, 32'h600 + 32'(i * 4), 1'b1, latency);
		end
		cpu_flush();
		for (int i = 0; i < 4; i++) begin
			cpu_read(1'b0, 32'h600 + 32'(i * 4), 1'b1, latency);
		end
		finish_test();

		start_test("reset_reinit");
		cpu_write(1'b1, 32'h700, 32'h0bad_0bad, 4'b1111);
		apply_reset();
		cpu_read(1'b1, 32'h700, 1'b0, latency);
		cpu_read(1'b1, 32'h604, 1'b0, latency);
		finish_test();

		start_test("random_mix");
		for (int n = 0; n < RANDOM_OPS; n++) begin
			pick = $urandom % 20;
			cacheable = 1'($urandom % 2);
			rw = 1'($urandom % 2);
			data = $urandom;
			mask = 4'($urandom % 16);
			if (cacheable) begin
				address = ($urandom % 512) << 2;
			end else begin
				address = UNCACHED_BASE + (($urandom % 256) << 2);
			end
			if (pick == 0) begin
				cpu_flush();
			end else if (rw) begin
				cpu_write(cacheable, address, data, mask);
			end else begin
				cpu_read(cacheable, address, 1'b0, latency);
			end
		end
		finish_test();

		$display("Tests run %0d, failed %0d; checks %0d, errors %0d",
			test_count, failed_tests, check_count, error_count);
		if (error_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== src.f ====
design/dcache_pkg.sv
design/dcache_bram.sv
design/dcache_controller.sv
design/bus_memory.sv
design/dcache_top.sv
tb/dcache_sva.sv
tb/dcache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the data cache testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module dcache_tb \
	-f src.f \
	-o dcache_sim

./obj_dir/dcache_sim 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi

echo "Simulation finished without failures"
exit 0
